// File: logic/spmm_data_pkg.sv
package spmm_data_pkg;

    localparam int DATA_W = 8;
    localparam int IDX_W = 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [IDX_W-1:0] idx_t;

    // One wider than an index so that the value N fits
    typedef logic [IDX_W:0] ptr_t;

    typedef struct packed {
        data_t value;
        idx_t  col;
    } lhs_nz_t;

    typedef struct packed {
        logic empty;
        idx_t slot;
    } row_sel_t;

endpackage

// File: logic/spmm_ctrl_pkg.sv
package spmm_ctrl_pkg;

    // Rows per beat on the right-load and output ports
    localparam int ROWS_PER_BEAT = 4;

    typedef enum logic [1:0] {
        RHS_EMPTY,
        RHS_LOAD,
        RHS_READY
    } rhs_state_t;

    typedef enum logic {
        OUT_IDLE,
        OUT_STREAM
    } out_state_t;

endpackage

// File: logic/rhs_buffer.sv
`timescale 1ns/1ps

module rhs_buffer #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic we,
    input  spmm_data_pkg::idx_t blk,
    input  spmm_data_pkg::data_t [spmm_ctrl_pkg::ROWS_PER_BEAT-1:0][N-1:0] rows,
    output spmm_data_pkg::data_t [N-1:0][N-1:0] columns
);

    localparam int RPB = spmm_ctrl_pkg::ROWS_PER_BEAT;

    // Row-major storage
    spmm_data_pkg::data_t [N-1:0][N-1:0] mem;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem <= '0;
        end else if (we) begin
            for (int r = 0; r < RPB; r++) begin
                mem[int'(blk) * RPB + r] <= rows[r];
            end
        end
    end

    // Each lane sees one column
    always_comb begin
        for (int c = 0; c < N; c++) begin
            for (int r = 0; r < N; r++) begin
                columns[c][r] = mem[r][c];
            end
        end
    end

endmodule

// File: logic/segment_decoder.sv
`timescale 1ns/1ps

module segment_decoder #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic lhs_start,
    input  spmm_data_pkg::ptr_t [N-1:0] ptr,
    output logic [N-1:0] seg_start,
    output spmm_data_pkg::row_sel_t [N-1:0] row_sel
);

    localparam int LG = $clog2(N);

    logic [N-1:0] start_d;
    spmm_data_pkg::row_sel_t [N-1:0] sel_d;
    spmm_data_pkg::row_sel_t [N-1:0] sel_pipe [LG+1];

    always_comb begin
        spmm_data_pkg::ptr_t prev;
        start_d = '0;
        start_d[0] = 1'b1;
        prev = '0;
        for (int r = 0; r < N; r++) begin
            // A row end below N opens the next segment
            if (int'(ptr[r]) < N) begin
                start_d[int'(ptr[r])] = 1'b1;
            end
            sel_d[r].slot = spmm_data_pkg::idx_t'(ptr[r] - 1'b1);
            sel_d[r].empty = (ptr[r] == prev);
            prev = ptr[r];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seg_start <= '0;
            for (int k = 0; k <= LG; k++) begin
                sel_pipe[k] <= '0;
            end
        end else begin
            if (lhs_start) begin
                seg_start <= start_d;
                sel_pipe[0] <= sel_d;
            end
            // Follows the scan levels
            for (int k = 1; k <= LG; k++) begin
                sel_pipe[k] <= sel_pipe[k-1];
            end
        end
    end

    assign row_sel = sel_pipe[LG];

endmodule

// File: logic/seg_scan.sv
`timescale 1ns/1ps

module seg_scan #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    input  spmm_data_pkg::data_t [N-1:0] values,
    input  logic [N-1:0] seg_start,
    output spmm_data_pkg::data_t [N-1:0] sums
);

    localparam int LG = $clog2(N);

    spmm_data_pkg::data_t [N-1:0] lvl_in [LG];
    spmm_data_pkg::data_t [N-1:0] lvl_q [LG];
    logic [N-1:0] flg_in [LG];
    // Last level needs no flags of its own
    logic [N-1:0] flg_q [LG-1];

    always_comb begin
        lvl_in[0] = values;
        flg_in[0] = seg_start;
        for (int l = 1; l < LG; l++) begin
            lvl_in[l] = lvl_q[l-1];
            flg_in[l] = flg_q[l-1];
        end
    end

    // A set flag means a segment starts inside the window, so stop adding
    always_ff @(posedge clock) begin
        for (int l = 0; l < LG; l++) begin
            for (int i = 0; i < N; i++) begin
                if (i < (1 << l) || flg_in[l][i]) begin
                    lvl_q[l][i] <= lvl_in[l][i];
                end else begin
                    lvl_q[l][i] <= lvl_in[l][i - (1 << l)] + lvl_in[l][i];
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < LG - 1; k++) begin
                flg_q[k] <= '0;
            end
        end else begin
            for (int l = 0; l < LG - 1; l++) begin
                for (int i = 0; i < N; i++) begin
                    if (i < (1 << l)) begin
                        flg_q[l][i] <= flg_in[l][i];
                    end else begin
                        flg_q[l][i] <= flg_in[l][i] | flg_in[l][i - (1 << l)];
                    end
                end
            end
        end
    end

    assign sums = lvl_q[LG-1];

endmodule

// File: logic/pe_lane.sv
`timescale 1ns/1ps

module pe_lane #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    input  spmm_data_pkg::lhs_nz_t [N-1:0] slots,
    input  spmm_data_pkg::data_t [N-1:0] column,
    input  logic [N-1:0] seg_start,
    input  spmm_data_pkg::row_sel_t [N-1:0] row_sel,
    output spmm_data_pkg::data_t [N-1:0] result
);

    localparam int LG = $clog2(N);

    spmm_data_pkg::data_t [N-1:0] products;
    spmm_data_pkg::data_t [N-1:0] sums;

    // Products wrap at the element width
    always_ff @(posedge clock) begin
        for (int s = 0; s < N; s++) begin
            products[s] <= slots[s].value * column[slots[s].col[LG-1:0]];
        end
    end

    seg_scan #(.N(N)) i_scan (
        .clock     (clock),
        .reset     (reset),
        .values    (products),
        .seg_start (seg_start),
        .sums      (sums)
    );

    // Row total sits at its last slot
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else begin
            for (int r = 0; r < N; r++) begin
                if (row_sel[r].empty) begin
                    result[r] <= '0;
                end else begin
                    result[r] <= sums[row_sel[r].slot[LG-1:0]];
                end
            end
        end
    end

endmodule

// File: logic/out_buffer.sv
`timescale 1ns/1ps

module out_buffer #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic capture,
    input  spmm_data_pkg::data_t [N-1:0][N-1:0] results,
    input  spmm_data_pkg::idx_t blk,
    output spmm_data_pkg::data_t [spmm_ctrl_pkg::ROWS_PER_BEAT-1:0][N-1:0] rows
);

    localparam int RPB = spmm_ctrl_pkg::ROWS_PER_BEAT;

    spmm_data_pkg::data_t [N-1:0][N-1:0] mem;

    // Lanes hold columns, the port wants rows
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem <= '0;
        end else if (capture) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    mem[r][c] <= results[c][r];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < RPB; k++) begin
            rows[k] = mem[int'(blk) * RPB + k];
        end
    end

endmodule

// File: logic/spmm_ctrl.sv
`timescale 1ns/1ps

module spmm_ctrl #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic rhs_start,
    input  logic lhs_start,
    output logic rhs_ready,
    output logic lhs_ready,
    output logic rhs_we,
    output spmm_data_pkg::idx_t rhs_blk,
    output logic capture,
    output logic out_valid,
    output spmm_data_pkg::idx_t out_blk
);

    localparam int LG = $clog2(N);
    localparam int BLOCKS = N / spmm_ctrl_pkg::ROWS_PER_BEAT;
    localparam spmm_data_pkg::idx_t LAST_BLK = spmm_data_pkg::idx_t'(BLOCKS - 1);

    spmm_ctrl_pkg::rhs_state_t rhs_state;
    spmm_ctrl_pkg::out_state_t out_state;
    spmm_data_pkg::idx_t load_blk;
    spmm_data_pkg::idx_t space_cnt;
    logic [LG+2:0] in_flight;
    logic rhs_take;
    logic lhs_take;

    // No reload while a product still needs the current matrix
    assign rhs_ready = (rhs_state != spmm_ctrl_pkg::RHS_LOAD) && (in_flight == '0);
    assign lhs_ready = (rhs_state == spmm_ctrl_pkg::RHS_READY) && (space_cnt == '0);

    assign rhs_take = rhs_start && rhs_ready;
    assign lhs_take = lhs_start && lhs_ready;

    // Block 0 goes in on the accepting edge, the rest follow back to back
    assign rhs_we = rhs_take || (rhs_state == spmm_ctrl_pkg::RHS_LOAD);
    assign rhs_blk = (rhs_state == spmm_ctrl_pkg::RHS_LOAD) ? load_blk : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rhs_state <= spmm_ctrl_pkg::RHS_EMPTY;
            load_blk <= '0;
        end else begin
            case (rhs_state)
                spmm_ctrl_pkg::RHS_LOAD: begin
                    if (load_blk == LAST_BLK) begin
                        rhs_state <= spmm_ctrl_pkg::RHS_READY;
                    end
                    load_blk <= load_blk + 1'b1;
                end
                default: begin
                    if (rhs_take) begin
                        if (BLOCKS == 1) begin
                            rhs_state <= spmm_ctrl_pkg::RHS_READY;
                        end else begin
                            rhs_state <= spmm_ctrl_pkg::RHS_LOAD;
                        end
                        load_blk <= spmm_data_pkg::idx_t'(1);
                    end
                end
            endcase
        end
    end

    // Issue spacing
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            space_cnt <= '0;
        end else if (lhs_take) begin
            space_cnt <= LAST_BLK;
        end else if (space_cnt != '0) begin
            space_cnt <= space_cnt - 1'b1;
        end
    end

    // Bit k set means a beat accepted k+1 cycles ago
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= {in_flight[LG+1:0], lhs_take};
        end
    end

    // Gather registers hold the result during this cycle
    assign capture = in_flight[LG+1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_state <= spmm_ctrl_pkg::OUT_IDLE;
            out_blk <= '0;
        end else begin
            case (out_state)
                spmm_ctrl_pkg::OUT_IDLE: begin
                    if (capture) begin
                        out_state <= spmm_ctrl_pkg::OUT_STREAM;
                        out_blk <= '0;
                    end
                end
                default: begin
                    if (out_blk == LAST_BLK) begin
                        out_blk <= '0;
                        // Next matrix captured on this edge keeps the stream going
                        if (!capture) begin
                            out_state <= spmm_ctrl_pkg::OUT_IDLE;
                        end
                    end else begin
                        out_blk <= out_blk + 1'b1;
                    end
                end
            endcase
        end
    end

    assign out_valid = (out_state == spmm_ctrl_pkg::OUT_STREAM);

endmodule

// File: logic/spmm_top.sv
`timescale 1ns/1ps

module spmm_top #(
    parameter int N = 16
) (
    input  logic clock,
    input  logic reset,
    output logic rhs_ready,
    input  logic rhs_start,
    input  spmm_data_pkg::data_t [spmm_ctrl_pkg::ROWS_PER_BEAT-1:0][N-1:0] rhs_rows,
    output logic lhs_ready,
    input  logic lhs_start,
    input  spmm_data_pkg::lhs_nz_t [N-1:0] lhs_slots,
    input  spmm_data_pkg::ptr_t [N-1:0] lhs_ptr,
    output logic out_valid,
    output spmm_data_pkg::data_t [spmm_ctrl_pkg::ROWS_PER_BEAT-1:0][N-1:0] out_rows
);

    logic rhs_we;
    logic capture;
    spmm_data_pkg::idx_t rhs_blk;
    spmm_data_pkg::idx_t out_blk;
    spmm_data_pkg::data_t [N-1:0][N-1:0] rhs_cols;
    spmm_data_pkg::data_t [N-1:0][N-1:0] lane_results;
    logic [N-1:0] seg_start;
    spmm_data_pkg::row_sel_t [N-1:0] row_sel;

    spmm_ctrl #(.N(N)) i_ctrl (
        .clock     (clock),
        .reset     (reset),
        .rhs_start (rhs_start),
        .lhs_start (lhs_start),
        .rhs_ready (rhs_ready),
        .lhs_ready (lhs_ready),
        .rhs_we    (rhs_we),
        .rhs_blk   (rhs_blk),
        .capture   (capture),
        .out_valid (out_valid),
        .out_blk   (out_blk)
    );

    rhs_buffer #(.N(N)) i_rhs_buffer (
        .clock   (clock),
        .reset   (reset),
        .we      (rhs_we),
        .blk     (rhs_blk),
        .rows    (rhs_rows),
        .columns (rhs_cols)
    );

    segment_decoder #(.N(N)) i_decoder (
        .clock     (clock),
        .reset     (reset),
        .lhs_start (lhs_start),
        .ptr       (lhs_ptr),
        .seg_start (seg_start),
        .row_sel   (row_sel)
    );

    // One lane per result column
    for (genvar c = 0; c < N; c++) begin : g_lane
        pe_lane #(.N(N)) i_lane (
            .clock     (clock),
            .reset     (reset),
            .slots     (lhs_slots),
            .column    (rhs_cols[c]),
            .seg_start (seg_start),
            .row_sel   (row_sel),
            .result    (lane_results[c])
        );
    end

    out_buffer #(.N(N)) i_out_buffer (
        .clock   (clock),
        .reset   (reset),
        .capture (capture),
        .results (lane_results),
        .blk     (out_blk),
        .rows    (out_rows)
    );

endmodule

// File: test/spmm_assert.sv
`timescale 1ns/1ps

module spmm_assert #(
    parameter int N = 16
) (
    input logic clock,
    input logic reset,
    input logic rhs_start,
    input logic rhs_ready,
    input logic lhs_ready,
    input logic capture,
    input logic out_valid,
    input spmm_data_pkg::idx_t out_blk
);

    localparam int BLOCKS = N / spmm_ctrl_pkg::ROWS_PER_BEAT;

    int fail_count = 0;

    // One stream of BLOCKS cycles per capture
    a_run_len: assert property (@(posedge clock) disable iff (reset)
        capture |=> out_valid [*BLOCKS] ##1 (!out_valid || $past(capture)))
        else begin
            fail_count++;
            $error("out_valid did not last %0d cycles after capture", BLOCKS);
        end

    // Left issue waits for the whole right matrix
    a_load_busy: assert property (@(posedge clock) disable iff (reset)
        (rhs_start && rhs_ready) |=> (!rhs_ready && !lhs_ready) [*BLOCKS-1] ##1 lhs_ready)
        else begin
            fail_count++;
            $error("ready flags wrong during or after a right matrix load");
        end

    // Capture during a stream lands on its last block and restarts at block 0
    a_capture: assert property (@(posedge clock) disable iff (reset)
        (capture && out_valid) |-> (out_blk == BLOCKS - 1) ##1 (out_valid && out_blk == 0))
        else begin
            fail_count++;
            $error("capture overlapped a running output stream");
        end

endmodule

bind spmm_ctrl spmm_assert #(.N(N)) i_assert (.*);

// File: test/spmm_tb.sv
`timescale 1ns/1ps

module spmm_tb;

    localparam int N = 16;
    localparam int LG = $clog2(N);
    localparam int RPB = spmm_ctrl_pkg::ROWS_PER_BEAT;
    localparam int BLOCKS = N / RPB;
    localparam int LIMIT = 40 * (BLOCKS + LG + 8) + 200;

    typedef spmm_data_pkg::data_t [N-1:0] row_t;
    typedef row_t [N-1:0] mat_t;

    logic clock = 1'b0;
    logic reset;
    logic rhs_ready;
    logic rhs_start;
    row_t [RPB-1:0] rhs_rows;
    logic lhs_ready;
    logic lhs_start;
    spmm_data_pkg::lhs_nz_t [N-1:0] lhs_slots;
    spmm_data_pkg::ptr_t [N-1:0] lhs_ptr;
    logic out_valid;
    row_t [RPB-1:0] out_rows;

    integer seed = 32'hd73b;
    int cycle = 0;
    int value_errors = 0;
    int other_errors = 0;
    int blk_idx = 0;
    mat_t rhs_mat;
    mat_t exp_q[$];
    int due_q[$];

    spmm_top #(.N(N)) i_dut (.*);

    always #10 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL at %0t: %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_row(input string name, input row_t expected, input row_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Row ends never decrease, steps of 0 give empty rows
    task automatic random_operands();
        int acc;
        acc = 0;
        for (int i = 0; i < N; i++) begin
            lhs_slots[i].value = spmm_data_pkg::data_t'($random(seed));
            lhs_slots[i].col = spmm_data_pkg::idx_t'($unsigned($random(seed)) % N);
            acc = acc + $unsigned($random(seed)) % 3;
            lhs_ptr[i] = spmm_data_pkg::ptr_t'((acc > N) ? N : acc);
        end
    endtask

    // Row r covers slots from the previous row end up to its own end
    function automatic mat_t model_product();
        mat_t res;
        int lo;
        res = '0;
        lo = 0;
        for (int r = 0; r < N; r++) begin
            for (int k = lo; k < int'(lhs_ptr[r]); k++) begin
                for (int c = 0; c < N; c++) begin
                    res[r][c] += lhs_slots[k].value * rhs_mat[lhs_slots[k].col][c];
                end
            end
            lo = int'(lhs_ptr[r]);
        end
        return res;
    endfunction

    task automatic load_rhs(input bit poke);
        while (!rhs_ready) next_cycle();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                rhs_mat[r][c] = spmm_data_pkg::data_t'($random(seed));
            end
        end
        for (int k = 0; k < BLOCKS; k++) begin
            // Start held into the second block
            rhs_start = (k == 0) || (poke && k == 1);
            for (int j = 0; j < RPB; j++) begin
                rhs_rows[j] = rhs_mat[k * RPB + j];
            end
            next_cycle();
            if (k < BLOCKS - 1) begin
                check_flag("rhs_ready", 1'b0, rhs_ready);
                check_flag("lhs_ready", 1'b0, lhs_ready);
            end
        end
        rhs_start = 1'b0;
        check_flag("rhs_ready", 1'b1, rhs_ready);
        check_flag("lhs_ready", 1'b1, lhs_ready);
    endtask

    task automatic issue(input bit poke);
        while (!lhs_ready) next_cycle();
        lhs_start = 1'b1;
        exp_q.push_back(model_product());
        due_q.push_back(cycle + LG + 3);
        next_cycle();
        // Both starts arrive while their ready is low
        lhs_start = poke;
        rhs_start = poke;
        if (poke) begin
            lhs_slots = ~lhs_slots;
            rhs_rows = ~rhs_rows;
        end
        for (int i = 0; i < BLOCKS - 1; i++) begin
            check_flag("lhs_ready", 1'b0, lhs_ready);
            next_cycle();
            lhs_start = 1'b0;
            rhs_start = 1'b0;
        end
        check_flag("lhs_ready", 1'b1, lhs_ready);
    endtask

    // One four-row block per cycle, sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && out_valid && exp_q.size() == 0) begin
            other_errors++;
            $display("Error at %0t: out_valid high with no product pending", $time);
        end else if (!reset && out_valid) begin
            if (blk_idx == 0 && cycle != due_q[0]) begin
                other_errors++;
                $display("Error at %0t: result began in cycle %0d but was due in cycle %0d",
                         $time, cycle, due_q[0]);
            end
            for (int j = 0; j < RPB; j++) begin
                check_row($sformatf("out_rows[%0d] (row %0d)", j, blk_idx * RPB + j),
                          exp_q[0][blk_idx * RPB + j], out_rows[j]);
            end
            blk_idx++;
        end else if (!reset && exp_q.size() != 0 && cycle >= due_q[0]) begin
            other_errors++;
            $display("Error at %0t: result stream missing or cut short", $time);
            blk_idx = BLOCKS;
        end
        if (blk_idx == BLOCKS) begin
            blk_idx = 0;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    // At most 40 products plus the loads
    initial begin
        while (cycle < LIMIT) @(posedge clock);
        other_errors++;
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 i_dut.i_ctrl.i_assert.fail_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        rhs_start = 1'b0;
        lhs_start = 1'b0;
        rhs_rows = '0;
        lhs_slots = '0;
        lhs_ptr = '0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        check_flag("rhs_ready", 1'b1, rhs_ready);
        check_flag("lhs_ready", 1'b0, lhs_ready);
        check_flag("out_valid", 1'b0, out_valid);
        // No right matrix held yet
        random_operands();
        lhs_start = 1'b1;
        repeat (LG + 4) begin
            next_cycle();
            lhs_start = 1'b0;
            check_flag("lhs_ready", 1'b0, lhs_ready);
        end
        load_rhs(1'b1);
        repeat (14) begin
            random_operands();
            issue(1'b0);
            while (exp_q.size() != 0) next_cycle();
        end
        // Empty, paired, one full row, diagonal, last row end below N
        for (int t = 0; t < 5; t++) begin
            random_operands();
            for (int r = 0; r < N; r++) begin
                case (t)
                    0: lhs_ptr[r] = '0;
                    1: lhs_ptr[r] = spmm_data_pkg::ptr_t'((r / 2) * 2);
                    2: lhs_ptr[r] = spmm_data_pkg::ptr_t'((r >= 5) ? N : 0);
                    3: lhs_ptr[r] = spmm_data_pkg::ptr_t'(r + 1);
                    default: lhs_ptr[r] = spmm_data_pkg::ptr_t'((r < 10) ? r + 1 : 10);
                endcase
                if (t == 3) begin
                    lhs_slots[r].col = spmm_data_pkg::idx_t'(r);
                end
            end
            issue(1'b0);
            while (exp_q.size() != 0) next_cycle();
        end
        // Full issue rate
        for (int i = 0; i < 16; i++) begin
            random_operands();
            issue(i % 4 == 1);
        end
        // Second reload waits out the products but not their output stream
        repeat (2) begin
            load_rhs(1'b0);
            repeat (2) begin
                random_operands();
                issue(1'b0);
            end
        end
        while (exp_q.size() != 0) next_cycle();
        repeat (4) next_cycle();
        check_flag("out_valid", 1'b0, out_valid);
        $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 i_dut.i_ctrl.i_assert.fail_count);
        if (value_errors + other_errors + i_dut.i_ctrl.i_assert.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: spmm_top.f
logic/spmm_data_pkg.sv
logic/spmm_ctrl_pkg.sv
logic/rhs_buffer.sv
logic/segment_decoder.sv
logic/seg_scan.sv
logic/pe_lane.sv
logic/out_buffer.sv
logic/spmm_ctrl.sv
logic/spmm_top.sv
test/spmm_assert.sv
test/spmm_tb.sv
